// File: verilog/fp24_pkg.sv
package fp24_pkg;

  // ====================
  // Format
  // ====================

  localparam int FP24_WIDTH  = 24;
  localparam int FP24_EXP_W  = 7;
  localparam int FP24_MANT_W = 16;

  localparam logic [FP24_EXP_W-1:0] FP24_BIAS = 7'd63;

  // Field view of one fp24 word.
  typedef struct packed {
    logic                   sign;
    logic [FP24_EXP_W-1:0]  exp;   // Zero field means the value is zero.
    logic [FP24_MANT_W-1:0] mant;  // Hidden one is not stored.
  } fp24_fields;

  // The reciprocal seed works on raw bits, the arithmetic on fields.
  typedef union packed {
    logic [FP24_WIDTH-1:0] raw;
    fp24_fields            f;
  } fp24;

  localparam fp24 FP24_TWO = 24'h400000;  // 2.0 is exponent 64 with mantissa 0.

  // Seed for 1/x.
  // Subtracting the low 23 bits negates the exponent and roughly inverts the mantissa.
  localparam logic [FP24_WIDTH-2:0] FP24_INV_MAGIC = 23'h7ddf0a;

  // ====================
  // Stage timing
  // ====================

  localparam int MUL_DELAY = 1;  // One register in fp24_mul.
  localparam int ADD_DELAY = 2;  // Align and add in fp24_add.

  // One Newton-Raphson step is mul, sub and mul.
  localparam int INV_STAGE_DELAY = MUL_DELAY + ADD_DELAY + MUL_DELAY;

endpackage

// File: verilog/pipeline.sv
`timescale 1ns/10ps

module pipeline #(
  parameter int width = 24,
  parameter int depth = 1
) (
  input  logic             clk,
  input  logic             en,
  input  logic [width-1:0] in,
  output logic [width-1:0] out
);

  // One entry per cycle of delay.
  logic [width-1:0] stage_q [depth];

  always_ff @(posedge clk) begin
    if (en) begin
      stage_q[0] <= in;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1];  // Everything moves together.
      end
    end
  end

  assign out = stage_q[depth-1];  // Oldest entry.

endmodule

// File: verilog/fp24_mul.sv
`timescale 1ns/10ps

module fp24_mul (
  input  logic         clk,
  input  logic         en,
  input  fp24_pkg::fp24 a,
  input  fp24_pkg::fp24 b,
  output fp24_pkg::fp24 prod
);

  localparam int mw = fp24_pkg::FP24_MANT_W;

  logic [mw:0]       ma;      // Mantissas with hidden one.
  logic [mw:0]       mb;
  logic [2*mw+1:0]   full;    // Full product in [1, 4).
  logic              carry;   // Product reached 2.0.
  logic [8:0]        exp_n;   // Room for the sum before the bias comes off.
  fp24_pkg::fp24     prod_d;

  assign ma    = {1'b1, a.f.mant};
  assign mb    = {1'b1, b.f.mant};
  assign full  = ma * mb;
  assign carry = full[2*mw+1];

  // Exponent sum less the bias and plus one when the product carried.
  assign exp_n = {2'b00, a.f.exp} + {2'b00, b.f.exp}
               - {2'b00, fp24_pkg::FP24_BIAS} + {8'd0, carry};

  always_comb begin
    prod_d.f.sign = a.f.sign ^ b.f.sign;
    prod_d.f.exp  = exp_n[fp24_pkg::FP24_EXP_W-1:0];  // Overflow is out of range.
    if (carry) begin
      prod_d.f.mant = full[2*mw -: mw];    // Drop the leading one at bit 33.
    end else begin
      prod_d.f.mant = full[2*mw-1 -: mw];  // Leading one sits at bit 32.
    end
    // Either operand zero forces a clean zero.
    if (a.f.exp == '0 || b.f.exp == '0) begin
      prod_d.raw = '0;
    end
  end

  // ====================
  // Output register
  // ====================

  always_ff @(posedge clk) begin
    if (en) begin
      prod <= prod_d;
    end
  end

endmodule

// File: verilog/fp24_add.sv
`timescale 1ns/10ps

module fp24_add (
  input  logic          clk,
  input  logic          en,
  input  fp24_pkg::fp24 a,
  input  fp24_pkg::fp24 b,
  input  logic          is_sub,  // High for a minus b.
  output fp24_pkg::fp24 sum
);

  localparam int mw = fp24_pkg::FP24_MANT_W;
  localparam int ew = fp24_pkg::FP24_EXP_W;
  localparam int aw = mw + 4;  // Hidden one, mantissa, three guard bits.

  // ====================
  // Stage 1 swaps and aligns
  // ====================

  fp24_pkg::fp24 b_eff;     // b with the operation folded into its sign.
  fp24_pkg::fp24 big;
  fp24_pkg::fp24 small_op;
  logic [ew-1:0] shift;
  logic [aw-1:0] small_m;
  logic [aw-1:0] small_al;

  always_comb begin
    b_eff        = b;
    b_eff.f.sign = b.f.sign ^ is_sub;
    // Magnitude compare on exponent and mantissa together.
    if ({b.f.exp, b.f.mant} > {a.f.exp, a.f.mant}) begin
      big      = b_eff;
      small_op = a;
    end else begin
      big      = a;
      small_op = b_eff;
    end
    shift   = big.f.exp - small_op.f.exp;  // Never negative after the swap.
    small_m = {(small_op.f.exp != '0), small_op.f.mant, 3'b000};
    if (shift >= ew'(aw)) begin
      small_al = '0;  // Shifted out entirely.
    end else begin
      small_al = small_m >> shift;
    end
  end

  logic          s1_sign;
  logic          s1_sub;
  logic [ew-1:0] s1_exp;
  logic [aw-1:0] s1_big_m;
  logic [aw-1:0] s1_small_m;

  always_ff @(posedge clk) begin
    if (en) begin
      s1_sign    <= big.f.sign;              // Result takes the larger sign.
      s1_sub     <= big.f.sign ^ small_op.f.sign;
      s1_exp     <= big.f.exp;
      s1_big_m   <= {(big.f.exp != '0), big.f.mant, 3'b000};
      s1_small_m <= small_al;
    end
  end

  // ====================
  // Stage 2 adds and normalizes
  // ====================

  logic [aw:0]   acc;    // One extra bit for the carry.
  logic [4:0]    lead;   // Position of the leading one.
  logic [aw:0]   norm;
  logic [7:0]    exp_n;
  fp24_pkg::fp24 sum_d;

  always_comb begin
    if (s1_sub) begin
      acc = {1'b0, s1_big_m} - {1'b0, s1_small_m};  // Big is never below small.
    end else begin
      acc = {1'b0, s1_big_m} + {1'b0, s1_small_m};
    end
    lead = '0;
    for (int i = 0; i <= aw; i++) begin
      if (acc[i]) begin
        lead = 5'(i);  // Last hit is the highest one.
      end
    end
    norm  = acc << (5'(aw) - lead);  // Leading one lands on bit aw.
    // Hidden one normally sits at bit aw-1, so shift the exponent by the difference.
    exp_n = {1'b0, s1_exp} + {3'b000, lead} - 8'(aw - 1);
    sum_d.f.sign = s1_sign;
    sum_d.f.exp  = exp_n[ew-1:0];
    sum_d.f.mant = norm[aw-1 -: mw];  // Guard bits fall off by truncation.
    if (acc == '0) begin
      sum_d.raw = '0;  // Exact cancellation.
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      sum <= sum_d;
    end
  end

endmodule

// File: verilog/fp24_inv_stage.sv
`timescale 1ns/10ps

module fp24_inv_stage (
  input  logic          clk,
  input  logic          en,
  input  fp24_pkg::fp24 x,
  input  fp24_pkg::fp24 y,       // Current guess for 1/x.
  output fp24_pkg::fp24 x_out,   // x delayed for the next stage.
  output fp24_pkg::fp24 y_next   // Refined guess.
);

  // Newton-Raphson step y * (2 - x*y).

  fp24_pkg::fp24 y_d;           // y lined up with the adder output.
  fp24_pkg::fp24 x_by_y;
  fp24_pkg::fp24 two_minus_xy;

  // Delay matching.
  pipeline #(.width(fp24_pkg::FP24_WIDTH), .depth(fp24_pkg::INV_STAGE_DELAY)) u_x_pipe (
    .clk(clk), .en(en), .in(x), .out(x_out)
  );
  pipeline #(
    .width(fp24_pkg::FP24_WIDTH),
    .depth(fp24_pkg::MUL_DELAY + fp24_pkg::ADD_DELAY)
  ) u_y_pipe (
    .clk(clk), .en(en), .in(y), .out(y_d)
  );

  fp24_mul u_mul_xy (.clk(clk), .en(en), .a(x), .b(y), .prod(x_by_y));

  fp24_add u_sub (
    .clk(clk), .en(en), .a(fp24_pkg::FP24_TWO), .b(x_by_y), .is_sub(1'b1),
    .sum(two_minus_xy)
  );

  fp24_mul u_mul_y (.clk(clk), .en(en), .a(y_d), .b(two_minus_xy), .prod(y_next));

endmodule

// File: verilog/fp24_inv.sv
`timescale 1ns/10ps

module fp24_inv #(
  parameter int nr_stages = 2  // 1 to 3.
) (
  input  logic          clk,
  input  logic          en,
  input  fp24_pkg::fp24 x,
  output fp24_pkg::fp24 x_inv  // nr_stages * INV_STAGE_DELAY cycles after x.
);

  // ====================
  // Seed
  // ====================

  fp24_pkg::fp24 seed;

  // Sign passes through and the rest is the magic constant minus the raw bits.
  // This negates the exponent and gives a rough mantissa in one subtract.
  assign seed.raw = {x.raw[fp24_pkg::FP24_WIDTH-1],
                     fp24_pkg::FP24_INV_MAGIC - x.raw[fp24_pkg::FP24_WIDTH-2:0]};

  // ====================
  // Refinement chain
  // ====================

  // Entry i feeds stage i; the last entry holds the final result.
  fp24_pkg::fp24 x_chain [nr_stages+1];
  fp24_pkg::fp24 y_chain [nr_stages+1];

  assign x_chain[0] = x;
  assign y_chain[0] = seed;

  for (genvar i = 0; i < nr_stages; i++) begin : g_stage
    // Each step roughly doubles the number of correct bits.
    fp24_inv_stage u_stage (
      .clk   (clk),
      .en    (en),
      .x     (x_chain[i]),
      .y     (y_chain[i]),
      .x_out (x_chain[i+1]),
      .y_next(y_chain[i+1])
    );
  end

  assign x_inv = y_chain[nr_stages];  // Last refined guess.

endmodule

// File: verilog/fp24_div.sv
`timescale 1ns/10ps

module fp24_div #(
  parameter int nr_stages = 2
) (
  input  logic          clk,
  input  logic          reset,
  input  fp24_pkg::fp24 num,
  input  fp24_pkg::fp24 den,
  input  logic          in_valid,
  output logic          in_ready,
  output fp24_pkg::fp24 quot,
  output logic          out_valid,
  input  logic          out_ready
);

  localparam int inv_delay = nr_stages * fp24_pkg::INV_STAGE_DELAY;
  localparam int div_delay = inv_delay + fp24_pkg::MUL_DELAY;  // 9 by default.

  logic          en;       // Global enable is low only while the output is blocked.
  logic          [div_delay-1:0] valid_q;  // One bit per pipeline slot.
  fp24_pkg::fp24 num_d;    // num lined up with 1/den.
  fp24_pkg::fp24 den_inv;

  assign en       = ~out_valid | out_ready;
  assign in_ready = en;

  // ====================
  // Datapath
  // ====================

  fp24_inv #(.nr_stages(nr_stages)) u_inv (.clk(clk), .en(en), .x(den), .x_inv(den_inv));

  pipeline #(.width(fp24_pkg::FP24_WIDTH), .depth(inv_delay)) u_num_pipe (
    .clk(clk), .en(en), .in(num), .out(num_d)
  );

  fp24_mul u_mul_q (.clk(clk), .en(en), .a(num_d), .b(den_inv), .prod(quot));  // num * 1/den.

  // ====================
  // Valid tracking
  // ====================

  // Data slots move on en whether or not they hold anything.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (en) begin
      valid_q <= {valid_q[div_delay-2:0], in_valid};  // in_ready is en here.
    end
  end

  assign out_valid = valid_q[div_delay-1];  // Holds with quot while stalled.

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int period = 100  // In ns.
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period / 2) clk = ~clk;  // Half period high, half low.

endmodule

// File: dv/fp24_div_chk.sv
`timescale 1ns/10ps

module fp24_div_chk (
  input logic          clk,
  input logic          reset,
  input logic          in_ready,
  input logic          out_valid,
  input logic          out_ready,
  input fp24_pkg::fp24 quot
);

  // A blocked output keeps its slot and its data.
  a_hold: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(quot.raw)))
    else $error("quot or out_valid moved while the output was blocked");

  // Input side stalls exactly when the output is blocked.
  a_ready: assert property (@(posedge clk) disable iff (reset)
    in_ready == (!out_valid || out_ready))
    else $error("in_ready does not follow the output stall");

  a_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid seen during reset");  // Valid chain is cleared.

endmodule

// File: dv/fp24_div_tb.sv
`timescale 1ns/10ps

module fp24_div_tb;

  localparam int div_latency = 2 * 4 + 1;  // Two NR stages plus the final multiply.
  localparam real max_rel_err = 1.0 / 4096.0;

  logic clk, reset, in_valid, in_ready, out_valid, out_ready, lat_phase, reset_q;
  fp24_pkg::fp24 num, den, quot;
  logic [31:0] lcg_state = 32'hc8b14d41;
  fp24_pkg::fp24 q_num[$], q_den[$];  // Scoreboard queues in acceptance order.
  int q_cycle[$];
  bit q_lat[$];
  int cycle = 0, n_in = 0, n_out = 0, timeouts = 0;
  int quot_errors = 0, count_errors = 0, flag_errors = 0;

  tb_clock #(.period(100)) u_clock (.clk(clk));

  fp24_div #(.nr_stages(2)) dut0 (.clk(clk), .reset(reset), .num(num), .den(den),
    .in_valid(in_valid), .in_ready(in_ready), .quot(quot), .out_valid(out_valid),
    .out_ready(out_ready));

  bind fp24_div fp24_div_chk u_chk (.clk(clk), .reset(reset), .in_ready(in_ready),
    .out_valid(out_valid), .out_ready(out_ready), .quot(quot));

  // ====================
  // Stimulus and model
  // ====================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_pct();
    return int'((lcg_next() >> 8) % 100);  // Upper bits are the better ones.
  endfunction

  function automatic fp24_pkg::fp24 rand_operand();
    fp24_pkg::fp24 v;
    logic [31:0] r;
    r = lcg_next();
    v.f.sign = r[31];
    v.f.exp  = 7'(40 + (r[30:24] % 47));  // Exponent 40 to 86 stays clear of the limits.
    v.f.mant = r[23:8];
    return v;
  endfunction

  // Value of a word is (-1)^s * 1.m * 2^(e - 63).
  function automatic real to_real(fp24_pkg::fp24 v);
    real m;
    if (v.f.exp == '0) return 0.0;
    m = (1.0 + real'(v.f.mant) / 65536.0) * (2.0 ** real'(int'(v.f.exp) - 63));
    return v.f.sign ? -m : m;
  endfunction

  task automatic compare_quot(input fp24_pkg::fp24 got, input real expected);
    real rel;
    logic exp_sign;
    exp_sign = (expected < 0.0);  // Sign of num/den is the xor of the signs.
    rel = (to_real(got) - expected) / expected;
    if (got.f.sign !== exp_sign) begin
      $display("** Error at %0t: quot.sign = %0b, expected %0b", $time, got.f.sign, exp_sign);
      quot_errors++;
    end
    if (rel > max_rel_err || rel < -max_rel_err) begin
      $display("** Error at %0t: quot = %h (%g), expected %g", $time, got.raw,
               to_real(got), expected);
      quot_errors++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
      count_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, expected);
      flag_errors++;
    end
  endtask

  // ====================
  // Scoreboard
  // ====================

  always @(posedge clk) begin : monitor
    if (reset_q) begin  // From the second reset edge to the first edge after it.
      compare_flag("out_valid", out_valid, 1'b0);
      compare_flag("in_ready", in_ready, 1'b1);
    end
    if (!reset && in_valid && in_ready) begin
      q_num.push_back(num);
      q_den.push_back(den);
      q_cycle.push_back(cycle);
      q_lat.push_back(lat_phase);
      n_in++;
    end
    if (!reset && out_valid && out_ready) begin
      n_out++;
      if (q_num.size() == 0) begin
        $display("Output at %0t with no accepted input waiting for it", $time);
        count_errors++;
      end else begin
        compare_quot(quot, to_real(q_num[0]) / to_real(q_den[0]));
        if (q_lat[0]) compare_count("latency", cycle - q_cycle[0], div_latency);
        void'(q_num.pop_front());
        void'(q_den.pop_front());
        void'(q_cycle.pop_front());
        void'(q_lat.pop_front());
      end
    end
    reset_q = reset;
    cycle++;
  end

  task automatic run_ops(input int n_ops, input bit random_ready);
    int sent;
    int cycles;
    sent = 0;
    cycles = 0;
    while (sent < n_ops && cycles < n_ops * 20) begin
      @(posedge clk);
      cycles++;
      if (in_valid && in_ready) sent++;
      if (sent >= n_ops) begin
        in_valid <= 1'b0;
      end else if (!in_valid || in_ready) begin  // Hold an offer until taken.
        in_valid <= (rand_pct() < 70);
        num      <= rand_operand();
        den      <= rand_operand();
      end
      out_ready <= random_ready ? (rand_pct() < 70) : 1'b1;
    end
    if (sent < n_ops) begin
      $display("Timeout: only %0d of %0d inputs were accepted", sent, n_ops);
      timeouts++;
    end
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    @(posedge clk);
    out_ready <= 1'b1;
    do begin
      @(negedge clk);  // Queue is stable away from the rising edge.
      cycles++;
    end while (q_num.size() != 0 && cycles < 200);
    if (q_num.size() != 0) begin
      $display("Timeout: %0d accepted inputs never came out", q_num.size());
      timeouts++;
    end
  endtask

  initial begin
    reset = 1'b1;
    reset_q = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    lat_phase = 1'b0;
    num = '0;
    den = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    run_ops(400, 1'b1);  // Random back-pressure.
    if (timeouts == 0) drain();
    lat_phase = 1'b1;  // Set away from the edge; output never stalls from here.
    if (timeouts == 0) run_ops(100, 1'b0);
    if (timeouts == 0) drain();
    compare_count("inputs", n_in, 500);
    compare_count("outputs", n_out, n_in);
    $display("Errors: quot %0d, count %0d, flag %0d, timeout %0d", quot_errors,
             count_errors, flag_errors, timeouts);
    if (quot_errors + count_errors + flag_errors + timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: fp24_div.f
verilog/fp24_pkg.sv
verilog/pipeline.sv
verilog/fp24_mul.sv
verilog/fp24_add.sv
verilog/fp24_inv_stage.sv
verilog/fp24_inv.sv
verilog/fp24_div.sv
dv/tb_clock.sv
dv/fp24_div_chk.sv
dv/fp24_div_tb.sv

// File: Makefile
TOP = fp24_div_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f fp24_div.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_bin
	@out="$$(./obj_dir/sim_bin)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean
